//--- wb_soc_pkg.sv
`default_nettype none

package wb_soc_pkg;

    // bus widths
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // region field of the word address
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 21;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // memory map
    localparam logic [REGION_W-1:0] RAM_REGION  = 9'h0;
    localparam logic [REGION_W-1:0] SYS_REGION  = 9'h1;
    localparam logic [ADDR_W-1:0]   SW_LED_ADDR = 30'h400001;

    // 1024 words, aliased across the RAM region
    localparam int RAM_AW = 10;

    // constant ID word of the system block
    localparam logic [DATA_W-1:0] SYS_ID_VALUE = 32'h20191028;

    // one master request
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    // response back toward a master
    typedef struct packed {
        logic              ack;
        logic              stall;
        logic              err;
        logic [DATA_W-1:0] data;
    } wb_rsp_t;

    // current bus owner of a priority arbiter
    typedef enum logic {
        OWNER_A = 1'b0,
        OWNER_B = 1'b1
    } owner_e;

    // word offsets inside the system block
    typedef enum logic [3:0] {
        SYS_ID      = 4'd0,
        SYS_SCRATCH = 4'd1,
        SYS_BUS_ERR = 4'd2,
        SYS_UPTIME  = 4'd3,
        SYS_IRQ     = 4'd4
    } sys_reg_e;

endpackage : wb_soc_pkg

`default_nettype wire

//--- wb_pri_arbiter.sv
`default_nettype none

module wb_pri_arbiter (
    input  wire logic                i_clk,
    input  wire logic                reset,
    input  wire wb_soc_pkg::wb_req_t i_a,
    input  wire wb_soc_pkg::wb_req_t i_b,
    input  wire wb_soc_pkg::wb_rsp_t i_rsp,
    output wb_soc_pkg::wb_rsp_t      o_a_rsp,
    output wb_soc_pkg::wb_rsp_t      o_b_rsp,
    output wb_soc_pkg::wb_req_t      o_req
);

    wb_soc_pkg::owner_e owner_q;
    wb_soc_pkg::owner_e grant;
    logic               owner_cyc;

    // owner keeps the bus for as long as it holds cyc
    always_comb begin
        owner_cyc = (owner_q == wb_soc_pkg::OWNER_A) ? i_a.cyc : i_b.cyc;
        if (owner_cyc) begin
            grant = owner_q;
        end else if (i_a.cyc || !i_b.cyc) begin
            // A first, and A parks the bus when both are idle
            grant = wb_soc_pkg::OWNER_A;
        end else begin
            grant = wb_soc_pkg::OWNER_B;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            owner_q <= wb_soc_pkg::OWNER_A;
        end else begin
            owner_q <= grant;
        end
    end

    // merged request follows the grant with no delay
    assign o_req = (grant == wb_soc_pkg::OWNER_A) ? i_a : i_b;

    // read data goes to both sides; handshake only to the owner
    always_comb begin
        o_a_rsp.data  = i_rsp.data;
        o_b_rsp.data  = i_rsp.data;
        o_a_rsp.ack   = 1'b0;
        o_b_rsp.ack   = 1'b0;
        o_a_rsp.err   = 1'b0;
        o_b_rsp.err   = 1'b0;
        // a waiting master is held off, an idle one sees no stall
        o_a_rsp.stall = i_a.cyc;
        o_b_rsp.stall = i_b.cyc;
        if (grant == wb_soc_pkg::OWNER_A) begin
            o_a_rsp.ack   = i_rsp.ack;
            o_a_rsp.err   = i_rsp.err;
            o_a_rsp.stall = i_rsp.stall;
        end else begin
            o_b_rsp.ack   = i_rsp.ack;
            o_b_rsp.err   = i_rsp.err;
            o_b_rsp.stall = i_rsp.stall;
        end
    end

endmodule : wb_pri_arbiter

`default_nettype wire

//--- wb_addr_decode.sv
`default_nettype none

module wb_addr_decode (
    input  wire logic                              i_clk,
    input  wire logic                              reset,
    input  wire wb_soc_pkg::wb_req_t               i_req,
    input  wire logic                              i_ram_ack,
    input  wire logic [wb_soc_pkg::DATA_W-1:0]     i_ram_data,
    input  wire logic                              i_sys_ack,
    input  wire logic [wb_soc_pkg::DATA_W-1:0]     i_sys_data,
    input  wire logic                              i_led_ack,
    input  wire logic [wb_soc_pkg::DATA_W-1:0]     i_led_data,
    output wb_soc_pkg::wb_rsp_t                    o_rsp,
    output logic                                   o_ram_stb,
    output logic                                   o_sys_stb,
    output logic                                   o_led_stb,
    output logic                                   o_bus_err
);

    logic [wb_soc_pkg::REGION_W-1:0] region;
    logic                            ram_sel;
    logic                            sys_sel;
    logic                            led_sel;
    logic                            none_sel;
    logic                            req_stb;
    logic                            ack_q;
    logic                            err_q;
    logic [wb_soc_pkg::DATA_W-1:0]   data_q;

    assign region = i_req.addr[wb_soc_pkg::REGION_MSB:wb_soc_pkg::REGION_LSB];

    // RAM and system block own whole regions, the port a single word
    assign ram_sel  = (region == wb_soc_pkg::RAM_REGION);
    assign sys_sel  = (region == wb_soc_pkg::SYS_REGION);
    assign led_sel  = (i_req.addr == wb_soc_pkg::SW_LED_ADDR);
    assign none_sel = !ram_sel && !sys_sel && !led_sel;

    assign req_stb = i_req.cyc && i_req.stb;

    assign o_ram_stb = req_stb && ram_sel;
    assign o_sys_stb = req_stb && sys_sel;
    assign o_led_stb = req_stb && led_sel;

    // handshake flags
    always_ff @(posedge i_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= i_ram_ack || i_sys_ack || i_led_ack;
            err_q <= req_stb && none_sel;
        end
    end

    // read data, zero when no slave answers
    always_ff @(posedge i_clk) begin
        if (i_ram_ack) begin
            data_q <= i_ram_data;
        end else if (i_sys_ack) begin
            data_q <= i_sys_data;
        end else if (i_led_ack) begin
            data_q <= i_led_data;
        end else begin
            data_q <= '0;
        end
    end

    // system block latches the failing address off this pulse
    assign o_bus_err = err_q;

    always_comb begin
        o_rsp.ack  = ack_q;
        o_rsp.err  = err_q;
        o_rsp.data = data_q;
        // every slave answers in one cycle, so the merged stall stays low
        o_rsp.stall = 1'b0;
    end

endmodule : wb_addr_decode

`default_nettype wire

//--- wb_sys_regs.sv
`default_nettype none

module wb_sys_regs (
    input  wire logic                          i_clk,
    input  wire logic                          reset,
    input  wire logic                          i_stb,
    input  wire wb_soc_pkg::wb_req_t           i_req,
    input  wire logic                          i_bus_err,
    input  wire logic [wb_soc_pkg::ADDR_W-1:0] i_err_addr,
    output logic                               o_ack,
    output logic [wb_soc_pkg::DATA_W-1:0]      o_data,
    output logic                               o_irq
);

    wb_soc_pkg::sys_reg_e          offset;
    logic [wb_soc_pkg::DATA_W-1:0] scratch;
    logic [wb_soc_pkg::ADDR_W-1:0] err_addr;
    logic [31:0]                   uptime;
    logic [31:0]                   uptime_inc;

    assign offset = wb_soc_pkg::sys_reg_e'(i_req.addr[3:0]);

    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_ack <= 1'b0;
            o_irq <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_req.we && offset == wb_soc_pkg::SYS_IRQ) begin
                o_irq <= i_req.data[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we && offset == wb_soc_pkg::SYS_SCRATCH) begin
            scratch <= i_req.data;
        end
    end

    // last unmapped word address
    always_ff @(posedge i_clk) begin
        if (reset) begin
            err_addr <= '0;
        end else if (i_bus_err) begin
            err_addr <= i_err_addr;
        end
    end

    // top bit sticks once reached, low bits wrap
    assign uptime_inc = uptime + 32'd1;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            uptime <= '0;
        end else begin
            uptime <= {uptime[31] | uptime_inc[31], uptime_inc[30:0]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (offset)
                wb_soc_pkg::SYS_ID:      o_data <= wb_soc_pkg::SYS_ID_VALUE;
                wb_soc_pkg::SYS_SCRATCH: o_data <= scratch;
                wb_soc_pkg::SYS_BUS_ERR: o_data <= {err_addr, 2'b00};
                wb_soc_pkg::SYS_UPTIME:  o_data <= uptime;
                wb_soc_pkg::SYS_IRQ:     o_data <= {31'd0, o_irq};
                default:                 o_data <= '0;
            endcase
        end
    end

endmodule : wb_sys_regs

`default_nettype wire

//--- wb_ram.sv
`default_nettype none

module wb_ram (
    input  wire logic                     i_clk,
    input  wire logic                     i_stb,
    input  wire wb_soc_pkg::wb_req_t      i_req,
    output logic                          o_ack,
    output logic [wb_soc_pkg::DATA_W-1:0] o_data
);

    localparam int DEPTH = 2 ** wb_soc_pkg::RAM_AW;

    logic [wb_soc_pkg::DATA_W-1:0] mem [DEPTH];
    logic [wb_soc_pkg::RAM_AW-1:0] idx;

    // upper address bits ignored, so the array repeats across its region
    assign idx = i_req.addr[wb_soc_pkg::RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we) begin
            for (int b = 0; b < wb_soc_pkg::SEL_W; b++) begin
                if (i_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= i_req.data[8*b +: 8];
                end
            end
        end
    end

    // read word lines up with the ack
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= mem[idx];
        end
    end

    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule : wb_ram

`default_nettype wire

//--- wb_sw_led.sv
`default_nettype none

module wb_sw_led (
    input  wire logic                     i_clk,
    input  wire logic                     reset,
    input  wire logic                     i_stb,
    input  wire wb_soc_pkg::wb_req_t      i_req,
    input  wire logic [15:0]              i_switches,
    output logic                          o_ack,
    output logic [wb_soc_pkg::DATA_W-1:0] o_data,
    output logic [15:0]                   o_leds
);

    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_ack  <= 1'b0;
            o_leds <= '0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_req.we) begin
                o_leds <= i_req.data[15:0];
            end
        end
    end

    // leds in the upper half, switches in the lower
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= {o_leds, i_switches};
        end
    end

endmodule : wb_sw_led

`default_nettype wire

//--- wb_soc_top.sv
`default_nettype none

module wb_soc_top (
    input  wire logic                i_clk,
    input  wire logic                reset,
    input  wire wb_soc_pkg::wb_req_t i_dfetch,
    input  wire wb_soc_pkg::wb_req_t i_ifetch,
    input  wire wb_soc_pkg::wb_req_t i_dbg,
    output wb_soc_pkg::wb_rsp_t      o_dfetch,
    output wb_soc_pkg::wb_rsp_t      o_ifetch,
    output wb_soc_pkg::wb_rsp_t      o_dbg,
    input  wire logic [15:0]         i_switches,
    output logic [15:0]              o_leds,
    output logic                     o_irq
);

    // internal bus between the two arbiters
    wb_soc_pkg::wb_req_t ibus_req;
    wb_soc_pkg::wb_rsp_t ibus_rsp;

    // main bus after the second arbiter
    wb_soc_pkg::wb_req_t mbus_req;
    wb_soc_pkg::wb_rsp_t mbus_rsp;

    // per slave handshake
    logic                          ram_stb;
    logic                          sys_stb;
    logic                          led_stb;
    logic                          ram_ack;
    logic                          sys_ack;
    logic                          led_ack;
    logic [wb_soc_pkg::DATA_W-1:0] ram_data;
    logic [wb_soc_pkg::DATA_W-1:0] sys_data;
    logic [wb_soc_pkg::DATA_W-1:0] led_data;
    logic                          bus_err;

    // data fetch beats instruction fetch
    wb_pri_arbiter ibus_arbiter (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a     (i_dfetch),
        .i_b     (i_ifetch),
        .i_rsp   (ibus_rsp),
        .o_a_rsp (o_dfetch),
        .o_b_rsp (o_ifetch),
        .o_req   (ibus_req)
    );

    // internal bus beats debug
    wb_pri_arbiter mbus_arbiter (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a     (ibus_req),
        .i_b     (i_dbg),
        .i_rsp   (mbus_rsp),
        .o_a_rsp (ibus_rsp),
        .o_b_rsp (o_dbg),
        .o_req   (mbus_req)
    );

    wb_addr_decode u_decode (
        .i_clk      (i_clk),
        .reset      (reset),
        .i_req      (mbus_req),
        .i_ram_ack  (ram_ack),
        .i_ram_data (ram_data),
        .i_sys_ack  (sys_ack),
        .i_sys_data (sys_data),
        .i_led_ack  (led_ack),
        .i_led_data (led_data),
        .o_rsp      (mbus_rsp),
        .o_ram_stb  (ram_stb),
        .o_sys_stb  (sys_stb),
        .o_led_stb  (led_stb),
        .o_bus_err  (bus_err)
    );

    // the failing master still drives its address during the err cycle
    wb_sys_regs u_sys (
        .i_clk      (i_clk),
        .reset      (reset),
        .i_stb      (sys_stb),
        .i_req      (mbus_req),
        .i_bus_err  (bus_err),
        .i_err_addr (mbus_req.addr),
        .o_ack      (sys_ack),
        .o_data     (sys_data),
        .o_irq      (o_irq)
    );

    wb_ram u_ram (
        .i_clk  (i_clk),
        .i_stb  (ram_stb),
        .i_req  (mbus_req),
        .o_ack  (ram_ack),
        .o_data (ram_data)
    );

    wb_sw_led u_sw_led (
        .i_clk      (i_clk),
        .reset      (reset),
        .i_stb      (led_stb),
        .i_req      (mbus_req),
        .i_switches (i_switches),
        .o_ack      (led_ack),
        .o_data     (led_data),
        .o_leds     (o_leds)
    );

endmodule : wb_soc_top

`default_nettype wire

//--- tb_wb_checker.sv
`default_nettype none

module tb_wb_checker (
    input wire logic                i_clk,
    input wire logic                reset,
    input wire wb_soc_pkg::wb_rsp_t i_dfetch,
    input wire wb_soc_pkg::wb_rsp_t i_ifetch,
    input wire wb_soc_pkg::wb_rsp_t i_dbg
);
    timeunit 1ns;
    timeprecision 100ps;

    int                  checks = 0;
    int                  errors = 0;
    bit                  armed     [3];
    int                  age       [3];
    string               tag       [3];
    logic                want_err  [3];
    logic                want_data [3];
    logic [31:0]         exp_data  [3];
    wb_soc_pkg::wb_rsp_t seen;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one access per master, armed on the cycle after acceptance
    task automatic arm(input int m, input string name, input logic err, input logic chk,
                       input logic [31:0] data);
        armed[m]     = 1'b1;
        age[m]       = 0;
        tag[m]       = name;
        want_err[m]  = err;
        want_data[m] = chk;
        exp_data[m]  = data;
    endtask

    function automatic wb_soc_pkg::wb_rsp_t response_of(input int m);
        case (m)
            0:       return i_dfetch;
            1:       return i_ifetch;
            default: return i_dbg;
        endcase
    endfunction

    // err is due one edge after acceptance, ack two edges after
    always @(posedge i_clk) begin
        if (!reset) begin
            for (int m = 0; m < 3; m++) begin
                seen = response_of(m);
                if (armed[m]) begin
                    age[m]++;
                    if (seen.ack || seen.err) begin
                        armed[m] = 1'b0;
                        check_value({tag[m], " latency"}, want_err[m] ? 1 : 2, age[m]);
                        check_value({tag[m], " err"}, want_err[m], seen.err);
                        check_value({tag[m], " ack"}, !want_err[m], seen.ack);
                        if (want_data[m]) begin
                            check_value({tag[m], " data"}, exp_data[m], seen.data);
                        end
                    end
                end else if (seen.ack || seen.err) begin
                    errors++;
                    $display("Error: master %0d got a response with no access outstanding", m);
                end
            end
        end
    end

endmodule : tb_wb_checker

`default_nettype wire

//--- tb_wb_soc.sv
`default_nettype none

module tb_wb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          M_DF     = 0;
    localparam int          M_IF     = 1;
    localparam int          M_DBG    = 2;
    localparam int          M_NONE   = 3;
    localparam int          TIMEOUT  = 50;
    localparam logic [29:0] SYS_BASE = 30'h200000;

    logic                clk = 1'b0;
    logic                reset;
    wb_soc_pkg::wb_req_t dfetch_req;
    wb_soc_pkg::wb_req_t ifetch_req;
    wb_soc_pkg::wb_req_t dbg_req;
    wb_soc_pkg::wb_rsp_t dfetch_rsp;
    wb_soc_pkg::wb_rsp_t ifetch_rsp;
    wb_soc_pkg::wb_rsp_t dbg_rsp;
    logic [15:0]         switches;
    logic [15:0]         leds;
    logic                irq;

    // stimulus table, one column per array
    int          n_tests = 0;
    string       t_name [32];
    int          t_m    [32];
    int          t_m2   [32];
    logic        t_we   [32];
    logic [29:0] t_addr [32];
    logic [31:0] t_data [32];
    logic [3:0]  t_sel  [32];
    logic [31:0] t_exp  [32];
    logic [31:0] t_exp2 [32];
    logic        t_err  [32];
    logic        t_chk  [32];
    logic [31:0] t_rd   [32];

    logic [31:0] ram_model [1024];
    logic [31:0] r [8];
    logic [31:0] rd_b;
    logic [15:0] leds_exp = '0;
    logic        irq_exp = 1'b0;
    int unsigned seed = 32'h2776_6798;
    int          stalls_a;
    int          stalls_b;
    int          up_idx;
    int          timeouts = 0;

    always #2 clk = ~clk;

    wb_soc_top i_dut (
        .i_clk      (clk),
        .reset      (reset),
        .i_dfetch   (dfetch_req),
        .i_ifetch   (ifetch_req),
        .i_dbg      (dbg_req),
        .o_dfetch   (dfetch_rsp),
        .o_ifetch   (ifetch_rsp),
        .o_dbg      (dbg_rsp),
        .i_switches (switches),
        .o_leds     (leds),
        .o_irq      (irq)
    );

    tb_wb_checker u_check (
        .i_clk    (clk),
        .reset    (reset),
        .i_dfetch (dfetch_rsp),
        .i_ifetch (ifetch_rsp),
        .i_dbg    (dbg_rsp)
    );

    function automatic string master_name(input int m);
        case (m)
            M_DF:    return "data fetch";
            M_IF:    return "instruction fetch";
            default: return "debug";
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wr,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wr[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic wb_soc_pkg::wb_rsp_t rsp_of(input int m);
        case (m)
            M_DF:    return dfetch_rsp;
            M_IF:    return ifetch_rsp;
            default: return dbg_rsp;
        endcase
    endfunction

    task automatic drive_req(input int m, input wb_soc_pkg::wb_req_t req);
        case (m)
            M_DF:    dfetch_req = req;
            M_IF:    ifetch_req = req;
            default: dbg_req = req;
        endcase
    endtask

    // RAM model tracks writes in table order, so reads see the state at that point
    task automatic add_entry(input string name, input int m, input int m2, input logic we,
                             input logic [29:0] addr, input logic [31:0] data,
                             input logic [3:0] sel, input logic [31:0] exp, input logic err,
                             input logic chk);
        t_name[n_tests] = name;
        t_m[n_tests]    = m;
        t_m2[n_tests]   = m2;
        t_we[n_tests]   = we;
        t_addr[n_tests] = addr;
        t_data[n_tests] = data;
        t_sel[n_tests]  = sel;
        t_exp[n_tests]  = exp;
        t_err[n_tests]  = err;
        t_chk[n_tests]  = chk;
        // second master reads the next word
        t_exp2[n_tests] = ram_model[addr[9:0] + 10'd1];
        if (we && addr[29:21] == 9'd0) begin
            ram_model[addr[9:0]] = merge_bytes(ram_model[addr[9:0]], data, sel);
        end
        n_tests++;
    endtask

    task automatic run_access(input int m, input int i, input logic [29:0] addr,
                              input logic [31:0] exp, input string name,
                              output int stalls, output logic [31:0] rd);
        wb_soc_pkg::wb_req_t req;
        wb_soc_pkg::wb_rsp_t rsp;
        int                  waited;
        logic                seen;
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = t_we[i];
        req.addr = addr;
        req.data = t_data[i];
        req.sel  = t_sel[i];
        stalls   = 0;
        rd       = '0;
        @(negedge clk);
        drive_req(m, req);
        // accepted on the first rising edge with stall low
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < TIMEOUT) begin
            @(posedge clk);
            rsp = rsp_of(m);
            if (rsp.stall) begin
                stalls++;
            end else begin
                seen = 1'b1;
            end
            waited++;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: %s master still stalled after %0d cycles", master_name(m),
                     TIMEOUT);
        end else begin
            @(negedge clk);
            req.stb = 1'b0;
            drive_req(m, req);
            u_check.arm(m, name, t_err[i], t_chk[i] && !t_we[i], exp);
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < TIMEOUT) begin
                @(posedge clk);
                rsp    = rsp_of(m);
                seen   = rsp.ack || rsp.err;
                rd     = rsp.data;
                waited++;
            end
            if (!seen) begin
                timeouts++;
                $display("Timeout: %s master got no ack or err within %0d cycles",
                         master_name(m), TIMEOUT);
            end
        end
        @(negedge clk);
        drive_req(m, '0);
    endtask

    initial begin
        r[0]       = $urandom(seed);
        reset      = 1'b1;
        dfetch_req = '0;
        ifetch_req = '0;
        dbg_req    = '0;
        for (int k = 1; k < 8; k++) begin
            r[k] = $urandom;
        end
        switches = r[7][15:0];
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        u_check.check_value("reset handshake", 0,
                            {dfetch_rsp.ack, dfetch_rsp.err, dfetch_rsp.stall,
                             ifetch_rsp.ack, ifetch_rsp.err, ifetch_rsp.stall,
                             dbg_rsp.ack, dbg_rsp.err, dbg_rsp.stall});
        u_check.check_value("reset leds", 0, leds);
        u_check.check_value("reset irq", 0, irq);

        add_entry("ram full write", M_DF, M_NONE, 1, 30'h10, r[0], 4'hf, 0, 0, 0);
        add_entry("ram full read", M_DF, M_NONE, 0, 30'h10, 0, 4'hf, ram_model[16], 0, 1);
        add_entry("ram byte write", M_DF, M_NONE, 1, 30'h10, r[1], 4'b0010, 0, 0, 0);
        add_entry("ram byte read", M_IF, M_NONE, 0, 30'h10, 0, 4'hf, ram_model[16], 0, 1);
        add_entry("ram alias read", M_DBG, M_NONE, 0, 30'h410, 0, 4'hf, ram_model[16], 0, 1);
        add_entry("sys id read", M_DF, M_NONE, 0, SYS_BASE, 0, 4'hf,
                  wb_soc_pkg::SYS_ID_VALUE, 0, 1);
        add_entry("scratch write", M_DF, M_NONE, 1, SYS_BASE + 1, r[2], 4'hf, 0, 0, 0);
        add_entry("scratch read", M_DBG, M_NONE, 0, SYS_BASE + 1, 0, 4'hf, r[2], 0, 1);
        add_entry("irq set", M_DF, M_NONE, 1, SYS_BASE + 4, 1, 4'hf, 0, 0, 0);
        add_entry("irq read", M_DF, M_NONE, 0, SYS_BASE + 4, 0, 4'hf, 1, 0, 1);
        add_entry("irq clear", M_DF, M_NONE, 1, SYS_BASE + 4, 0, 4'hf, 0, 0, 0);
        add_entry("unmapped read", M_DF, M_NONE, 0, 30'h400000, 0, 4'hf, 0, 1, 0);
        add_entry("bus err read", M_DF, M_NONE, 0, SYS_BASE + 2, 0, 4'hf,
                  {30'h400000, 2'b00}, 0, 1);
        add_entry("led write", M_DF, M_NONE, 1, wb_soc_pkg::SW_LED_ADDR, r[3], 4'hf, 0, 0, 0);
        add_entry("led read", M_IF, M_NONE, 0, wb_soc_pkg::SW_LED_ADDR, 0, 4'hf,
                  {r[3][15:0], switches}, 0, 1);
        add_entry("ram write a", M_DF, M_NONE, 1, 30'h20, r[4], 4'hf, 0, 0, 0);
        add_entry("ram write b", M_DF, M_NONE, 1, 30'h21, r[5], 4'hf, 0, 0, 0);
        add_entry("ram write c", M_DF, M_NONE, 1, 30'h22, r[6], 4'hf, 0, 0, 0);
        add_entry("dfetch vs ifetch", M_DF, M_IF, 0, 30'h20, 0, 4'hf, ram_model[32], 0, 1);
        add_entry("ifetch vs debug", M_IF, M_DBG, 0, 30'h21, 0, 4'hf, ram_model[33], 0, 1);
        up_idx = n_tests;
        add_entry("uptime first", M_DF, M_NONE, 0, SYS_BASE + 3, 0, 4'hf, 0, 0, 0);
        add_entry("uptime second", M_DBG, M_NONE, 0, SYS_BASE + 3, 0, 4'hf, 0, 0, 0);

        for (int i = 0; i < n_tests && timeouts == 0; i++) begin
            if (t_m2[i] == M_NONE) begin
                run_access(t_m[i], i, t_addr[i], t_exp[i], t_name[i], stalls_a, t_rd[i]);
            end else begin
                // both masters raise cyc on the same edge
                fork
                    run_access(t_m[i], i, t_addr[i], t_exp[i], t_name[i], stalls_a, t_rd[i]);
                    run_access(t_m2[i], i, t_addr[i] + 30'd1, t_exp2[i],
                               {t_name[i], " second"}, stalls_b, rd_b);
                join
                u_check.check_value({t_name[i], " winner stall"}, 0, stalls_a);
                // loser held off on the winner's accepting edge and the two edges up to its ack
                u_check.check_value({t_name[i], " loser stall cycles"}, 3, stalls_b);
            end
            if (t_we[i] && t_addr[i] == wb_soc_pkg::SW_LED_ADDR) begin
                leds_exp = t_data[i][15:0];
            end
            if (t_we[i] && t_addr[i] == SYS_BASE + 4) begin
                irq_exp = t_data[i][0];
            end
            u_check.check_value({t_name[i], " leds"}, leds_exp, leds);
            u_check.check_value({t_name[i], " irq"}, irq_exp, irq);
            repeat (3) @(negedge clk);
        end
        if (timeouts == 0) begin
            u_check.check_value("uptime increase", 1, t_rd[up_idx + 1] > t_rd[up_idx]);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", u_check.checks, u_check.errors,
                 timeouts);
        if (u_check.errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_wb_soc

`default_nettype wire

//--- build.f
wb_soc_pkg.sv
wb_pri_arbiter.sv
wb_addr_decode.sv
wb_sys_regs.sv
wb_ram.sv
wb_sw_led.sv
wb_soc_top.sv
tb_wb_checker.sv
tb_wb_soc.sv
